// ==== design/ddr_bridge_pkg.sv ====
/*
 * Widths are fixed by the DDR2 controller core: a 256-bit line moves as two 128-bit beats.
 * The app address counts x16 columns, so one 16-byte beat advances it by 8.
 */
package ddr_bridge_pkg;

    // --------------------------------------------------
    // data and address widths
    // --------------------------------------------------
    localparam int LINE_W    = 256;
    localparam int BEAT_W    = 128;
    localparam int WB_ADR_W  = 30;
    localparam int APP_ADR_W = 27;

    localparam int BEATS_PER_LINE = 2;

    // beat select width and counter width (counter must reach BEATS_PER_LINE)
    localparam int BEAT_SEL_W = $clog2(BEATS_PER_LINE);
    localparam int BEAT_CNT_W = $clog2(BEATS_PER_LINE + 1);

    // 16 bytes per beat in 2-byte column units
    localparam logic [APP_ADR_W-1:0] BEAT_ADR_STEP = 8;

    // --------------------------------------------------
    // app command and sequencer states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'b000,
        APP_CMD_READ  = 3'b001
    } app_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ_CMD,
        ST_READ_WAIT,
        ST_ACK
    } line_state_e;

endpackage

// ==== design/line_ctl_if.sv ====
/*
 * Beat control from the line sequencer to the write and read data paths.
 * All signals are in the ui_clk domain.
 */
interface line_ctl_if;

    // write side
    logic                                  wr_load;
    logic [ddr_bridge_pkg::BEAT_SEL_W-1:0] cmd_beat;

    // read side
    logic                                  rd_store;
    logic [ddr_bridge_pkg::BEAT_SEL_W-1:0] rd_beat;
    logic                                  rd_clear;

    modport fsm (
        output wr_load,
        output cmd_beat,
        output rd_store,
        output rd_beat,
        output rd_clear
    );

    modport wr (input wr_load, input cmd_beat);

    modport rd (input rd_store, input rd_beat, input rd_clear);

endinterface

// ==== design/beat_counter.sv ====
/*
 * Counts accepted beats up to BEATS_PER_LINE and then holds.
 * done is registered and stays high until clear.
 */
module beat_counter (
    input  logic                                  ui_clk,
    input  logic                                  rst,
    input  logic                                  clear,
    input  logic                                  advance,
    output logic [ddr_bridge_pkg::BEAT_CNT_W-1:0] count,
    output logic                                  done
);

    logic last;

    // advancing from here completes the line
    assign last = (count == ddr_bridge_pkg::BEATS_PER_LINE - 1);

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            count <= '0;
            done  <= 1'b0;
        end else if (clear) begin
            count <= '0;
            done  <= 1'b0;
        end else if (advance && !done) begin
            count <= count + 1'b1;
            done  <= last;
        end
    end

endmodule

// ==== design/wr_line_path.sv ====
/*
 * Holds the write line from request time, so the master may change its data after ack.
 * Beat 0 is the low half of the line.
 */
module wr_line_path (
    input  logic                              ui_clk,
    input  logic                              rst,
    input  logic [ddr_bridge_pkg::LINE_W-1:0] line_in,
    output logic [ddr_bridge_pkg::BEAT_W-1:0] beat_data,
    line_ctl_if.wr                            ctl
);

    logic [ddr_bridge_pkg::LINE_W-1:0] line_q;

    // --------------------------------------------------
    // line capture
    // --------------------------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            line_q <= '0;
        end else if (ctl.wr_load) begin
            line_q <= line_in;
        end
    end

    // --------------------------------------------------
    // beat select
    // --------------------------------------------------
    // follows the command beat with no register, so data stays
    // aligned with app_en while app_rdy is low
    assign beat_data = line_q[ctl.cmd_beat * ddr_bridge_pkg::BEAT_W +: ddr_bridge_pkg::BEAT_W];

endmodule

// ==== design/rd_line_path.sv ====
/*
 * Assembles returned read beats into the line, beat 0 into the low half.
 * The line is cleared at the start of each read and holds until the next one.
 */
module rd_line_path (
    input  logic                              ui_clk,
    input  logic                              rst,
    input  logic [ddr_bridge_pkg::BEAT_W-1:0] beat_in,
    output logic [ddr_bridge_pkg::LINE_W-1:0] line_out,
    line_ctl_if.rd                            ctl
);

    logic [ddr_bridge_pkg::LINE_W-1:0] line_q;

    // --------------------------------------------------
    // beat store
    // --------------------------------------------------
    // a cleared line means a missing beat shows up as zeros
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            line_q <= '0;
        end else if (ctl.rd_clear) begin
            line_q <= '0;
        end else if (ctl.rd_store) begin
            line_q[ctl.rd_beat * ddr_bridge_pkg::BEAT_W +: ddr_bridge_pkg::BEAT_W] <= beat_in;
        end
    end

    assign line_out = line_q;

endmodule

// ==== design/ddr_line_fsm.sv ====
/*
 * Sequences one Wishbone classic cycle into BEATS_PER_LINE app commands.
 * Requests wait in idle until init_calib_complete. Write beats need app_rdy and app_wdf_rdy.
 * Read data is counted apart from commands, so two reads may be in flight.
 */
module ddr_line_fsm (
    input  logic                     ui_clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic                     init_calib_complete,
    input  logic                     app_rdy,
    input  logic                     app_wdf_rdy,
    input  logic                     app_rd_data_valid,
    output logic                     app_en,
    output logic                     app_wdf_wren,
    output ddr_bridge_pkg::app_cmd_e app_cmd,
    output logic                     wb_ack,
    output logic                     addr_load,
    line_ctl_if.fsm                  ctl
);

    ddr_bridge_pkg::line_state_e state;
    ddr_bridge_pkg::line_state_e state_next;

    logic is_write;
    logic req_take;
    logic cmd_take;
    logic cmd_last;
    logic data_take;
    logic data_done;

    logic [ddr_bridge_pkg::BEAT_CNT_W-1:0] cmd_count;
    logic [ddr_bridge_pkg::BEAT_CNT_W-1:0] data_count;

    // --------------------------------------------------
    // request capture
    // --------------------------------------------------
    assign req_take = (state == ddr_bridge_pkg::ST_IDLE) && wb_cyc && wb_stb
                      && init_calib_complete;

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            is_write <= 1'b0;
        end else if (req_take) begin
            is_write <= wb_we;
        end
    end

    assign addr_load    = req_take;
    assign ctl.wr_load  = req_take && wb_we;
    assign ctl.rd_clear = req_take && !wb_we;

    // --------------------------------------------------
    // command issue
    // --------------------------------------------------
    assign app_en = (state == ddr_bridge_pkg::ST_WRITE) ||
                    (state == ddr_bridge_pkg::ST_READ_CMD);

    // write data goes out with its command
    assign app_wdf_wren = app_en && is_write;
    assign app_cmd      = is_write ? ddr_bridge_pkg::APP_CMD_WRITE
                                   : ddr_bridge_pkg::APP_CMD_READ;

    assign cmd_take = app_en && app_rdy && (app_wdf_rdy || !is_write);
    assign cmd_last = (cmd_count == ddr_bridge_pkg::BEATS_PER_LINE - 1);

    assign ctl.cmd_beat = cmd_count[ddr_bridge_pkg::BEAT_SEL_W-1:0];

    beat_counter cmd_cnt_i (
        .ui_clk  (ui_clk),
        .rst     (rst),
        .clear   (req_take),
        .advance (cmd_take),
        .count   (cmd_count),
        .done    ()
    );

    // --------------------------------------------------
    // read data return
    // --------------------------------------------------
    // beats may come back while the second command is still pending
    assign data_take = app_rd_data_valid &&
                       ((state == ddr_bridge_pkg::ST_READ_CMD) ||
                        (state == ddr_bridge_pkg::ST_READ_WAIT));

    assign ctl.rd_store = data_take;
    assign ctl.rd_beat  = data_count[ddr_bridge_pkg::BEAT_SEL_W-1:0];

    beat_counter data_cnt_i (
        .ui_clk  (ui_clk),
        .rst     (rst),
        .clear   (req_take),
        .advance (data_take),
        .count   (data_count),
        .done    (data_done)
    );

    // --------------------------------------------------
    // state register
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ddr_bridge_pkg::ST_IDLE: begin
                if (req_take) begin
                    state_next = wb_we ? ddr_bridge_pkg::ST_WRITE
                                       : ddr_bridge_pkg::ST_READ_CMD;
                end
            end
            ddr_bridge_pkg::ST_WRITE: begin
                if (cmd_take && cmd_last) begin
                    state_next = ddr_bridge_pkg::ST_ACK;
                end
            end
            ddr_bridge_pkg::ST_READ_CMD: begin
                if (cmd_take && cmd_last) begin
                    state_next = ddr_bridge_pkg::ST_READ_WAIT;
                end
            end
            ddr_bridge_pkg::ST_READ_WAIT: begin
                if (data_done) begin
                    state_next = ddr_bridge_pkg::ST_ACK;
                end
            end
            ddr_bridge_pkg::ST_ACK: begin
                state_next = ddr_bridge_pkg::ST_IDLE;
            end
            default: begin
                state_next = ddr_bridge_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state <= ddr_bridge_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ST_ACK always returns to idle so ack lasts one cycle
    assign wb_ack = (state == ddr_bridge_pkg::ST_ACK);

endmodule

// ==== design/ddr_bridge_top.sv ====
/*
 * Wishbone classic slave to DDR2 app interface bridge, all on ui_clk.
 * Full 256-bit lines only, no byte masks; upper Wishbone address bits are dropped.
 * No request is served before init_calib_complete.
 */
module ddr_bridge_top (
    // wishbone side
    input  logic                                 ui_clk,
    input  logic                                 rst,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [ddr_bridge_pkg::WB_ADR_W-1:0]  wb_adr,
    input  logic [ddr_bridge_pkg::LINE_W-1:0]    wb_dat_w,
    output logic [ddr_bridge_pkg::LINE_W-1:0]    wb_dat_r,
    output logic                                 wb_ack,

    // app side
    output logic [ddr_bridge_pkg::APP_ADR_W-1:0] app_addr,
    output ddr_bridge_pkg::app_cmd_e             app_cmd,
    output logic                                 app_en,
    output logic [ddr_bridge_pkg::BEAT_W-1:0]    app_wdf_data,
    output logic                                 app_wdf_wren,
    output logic                                 app_wdf_end,
    input  logic                                 app_rdy,
    input  logic                                 app_wdf_rdy,
    input  logic [ddr_bridge_pkg::BEAT_W-1:0]    app_rd_data,
    input  logic                                 app_rd_data_valid,
    input  logic                                 init_calib_complete
);

    logic                                 addr_load;
    logic [ddr_bridge_pkg::APP_ADR_W-1:0] addr_base;
    logic [ddr_bridge_pkg::APP_ADR_W-1:0] beat_offset;

    line_ctl_if ctl ();

    // --------------------------------------------------
    // app address
    // --------------------------------------------------
    // word address times 2 gives x16 column units
    always_ff @(posedge ui_clk) begin
        if (addr_load) begin
            addr_base <= {wb_adr[ddr_bridge_pkg::APP_ADR_W-2:0], 1'b0};
        end
    end

    assign beat_offset = ddr_bridge_pkg::BEAT_ADR_STEP * ctl.cmd_beat;
    assign app_addr    = addr_base + beat_offset;

    // every beat ends its own write burst
    assign app_wdf_end = 1'b1;

    // --------------------------------------------------
    // sequencer and data paths
    // --------------------------------------------------
    ddr_line_fsm fsm_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_we               (wb_we),
        .init_calib_complete (init_calib_complete),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data_valid   (app_rd_data_valid),
        .app_en              (app_en),
        .app_wdf_wren        (app_wdf_wren),
        .app_cmd             (app_cmd),
        .wb_ack              (wb_ack),
        .addr_load           (addr_load),
        .ctl                 (ctl.fsm)
    );

    wr_line_path wr_path_i (
        .ui_clk    (ui_clk),
        .rst       (rst),
        .line_in   (wb_dat_w),
        .beat_data (app_wdf_data),
        .ctl       (ctl.wr)
    );

    // read line is valid on wb_dat_r while wb_ack is high
    rd_line_path rd_path_i (
        .ui_clk   (ui_clk),
        .rst      (rst),
        .beat_in  (app_rd_data),
        .line_out (wb_dat_r),
        .ctl      (ctl.rd)
    );

endmodule

// ==== tb/mig_app_model.sv ====
/*
 * Behavioral DDR2 app-side memory. Unwritten beats read back a fill of their own app address.
 * Ready drops and read latency (2 to 8 cycles) are random, and read beats return in order.
 * Protocol problems are printed in plain words and raise protocol_err.
 */
module mig_app_model (
    input  logic                                 ui_clk,
    input  logic                                 rst,
    input  logic [ddr_bridge_pkg::APP_ADR_W-1:0] app_addr,
    input  ddr_bridge_pkg::app_cmd_e             app_cmd,
    input  logic                                 app_en,
    input  logic [ddr_bridge_pkg::BEAT_W-1:0]    app_wdf_data,
    input  logic                                 app_wdf_wren,
    input  logic                                 app_wdf_end,
    output logic                                 app_rdy,
    output logic                                 app_wdf_rdy,
    output logic [ddr_bridge_pkg::BEAT_W-1:0]    app_rd_data,
    output logic                                 app_rd_data_valid,
    output logic                                 init_calib_complete,
    output logic                                 protocol_err
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [ddr_bridge_pkg::BEAT_W-1:0]    mem [logic [ddr_bridge_pkg::APP_ADR_W-1:0]];
    logic [ddr_bridge_pkg::APP_ADR_W-1:0] rd_adr_q [$];
    int                                   rd_due_q [$];

    // the beat a stalled command must keep presenting
    logic                                 hold_pending;
    logic [ddr_bridge_pkg::APP_ADR_W-1:0] hold_addr;
    ddr_bridge_pkg::app_cmd_e             hold_cmd;
    logic [ddr_bridge_pkg::BEAT_W-1:0]    hold_data;

    logic                                 beat_phase;
    logic [ddr_bridge_pkg::APP_ADR_W-1:0] beat0_addr;
    int                                   cycle;
    int                                   calib_cnt;

    // each 32-bit word holds the app address of its beat
    function automatic logic [ddr_bridge_pkg::BEAT_W-1:0] fill_beat(
        input logic [ddr_bridge_pkg::APP_ADR_W-1:0] a);
        return {4{5'b0, a}};
    endfunction

    task automatic flag_error(input string what);
        $display("memory model error at %0t ns: %s", $time, what);
        protocol_err <= 1'b1;
    endtask

    initial begin
        logic accept;
        int   due;
        logic [ddr_bridge_pkg::APP_ADR_W-1:0] rd_adr;

        app_rdy             = 1'b0;
        app_wdf_rdy         = 1'b0;
        app_rd_data         = '0;
        app_rd_data_valid   = 1'b0;
        init_calib_complete = 1'b0;
        protocol_err        = 1'b0;
        hold_pending        = 1'b0;
        beat_phase          = 1'b0;
        cycle               = 0;
        calib_cnt           = 0;
        void'($urandom(32'h80b6d391));
        forever begin
            @(posedge ui_clk);
            cycle++;
            if (!rst) begin
                calib_cnt = 0;
                init_calib_complete <= 1'b0;
                app_rd_data_valid   <= 1'b0;
                rd_adr_q.delete();
                rd_due_q.delete();
                hold_pending = 1'b0;
                beat_phase   = 1'b0;
            end else begin
                accept = app_en && app_rdy && (app_wdf_rdy || app_cmd == ddr_bridge_pkg::APP_CMD_READ);

                // --------------------------------------------------
                // handshake rules
                // --------------------------------------------------
                if (app_wdf_wren !== (app_en && app_cmd == ddr_bridge_pkg::APP_CMD_WRITE)) begin
                    flag_error("write data enable does not match the write command");
                end
                if (app_wdf_wren && app_wdf_end !== 1'b1) begin
                    flag_error("write beat without app_wdf_end");
                end
                if (app_en && !init_calib_complete) begin
                    flag_error("command issued before calibration completed");
                end
                if (hold_pending && (!app_en || app_addr != hold_addr || app_cmd != hold_cmd ||
                    (hold_cmd == ddr_bridge_pkg::APP_CMD_WRITE && app_wdf_data != hold_data))) begin
                    flag_error("stalled beat changed or was dropped while ready was low");
                end

                // --------------------------------------------------
                // accepted commands
                // --------------------------------------------------
                if (accept) begin
                    if (!beat_phase) begin
                        beat0_addr = app_addr;
                    end else if (app_addr != beat0_addr + 8) begin
                        flag_error($sformatf("beat 1 address %h is not beat 0 address %h plus 8",
                                             app_addr, beat0_addr));
                    end
                    beat_phase = !beat_phase;
                    if (app_cmd == ddr_bridge_pkg::APP_CMD_WRITE) begin
                        mem[app_addr] = app_wdf_data;
                    end else begin
                        due = cycle + 2 + ($urandom % 7);
                        if (rd_due_q.size() > 0 && due <= rd_due_q[$]) begin
                            due = rd_due_q[$] + 1;
                        end
                        rd_adr_q.push_back(app_addr);
                        rd_due_q.push_back(due);
                    end
                end
                hold_pending = app_en && !accept;
                hold_addr    = app_addr;
                hold_cmd     = app_cmd;
                hold_data    = app_wdf_data;

                // read return, one beat per cycle in command order
                if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                    rd_adr = rd_adr_q.pop_front();
                    void'(rd_due_q.pop_front());
                    app_rd_data       <= mem.exists(rd_adr) ? mem[rd_adr] : fill_beat(rd_adr);
                    app_rd_data_valid <= 1'b1;
                end else begin
                    app_rd_data_valid <= 1'b0;
                end

                app_rdy     <= ($urandom % 4) != 0;
                app_wdf_rdy <= ($urandom % 4) != 0;
                if (calib_cnt < 30) begin
                    calib_cnt++;
                end
                init_calib_complete <= (calib_cnt == 30);
            end
        end
    end

endmodule

// ==== tb/ddr_bridge_tb.sv ====
/*
 * Bridge testbench. Operations come from tb/ddr_bridge_stimulus.txt, run from the project root.
 * The first request goes out before calibration and must wait for it.
 */
module ddr_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                 ui_clk = 1'b0;
    logic                                 rst;
    logic                                 wb_cyc;
    logic                                 wb_stb;
    logic                                 wb_we;
    logic [ddr_bridge_pkg::WB_ADR_W-1:0]  wb_adr;
    logic [ddr_bridge_pkg::LINE_W-1:0]    wb_dat_w;
    logic [ddr_bridge_pkg::LINE_W-1:0]    wb_dat_r;
    logic                                 wb_ack;
    logic [ddr_bridge_pkg::APP_ADR_W-1:0] app_addr;
    ddr_bridge_pkg::app_cmd_e             app_cmd;
    logic                                 app_en;
    logic [ddr_bridge_pkg::BEAT_W-1:0]    app_wdf_data;
    logic                                 app_wdf_wren;
    logic                                 app_wdf_end;
    logic                                 app_rdy;
    logic                                 app_wdf_rdy;
    logic [ddr_bridge_pkg::BEAT_W-1:0]    app_rd_data;
    logic                                 app_rd_data_valid;
    logic                                 init_calib_complete;
    logic                                 protocol_err;

    // operations from the stimulus file
    bit                                   op_write [$];
    logic [ddr_bridge_pkg::WB_ADR_W-1:0]  op_adr [$];
    logic [ddr_bridge_pkg::LINE_W-1:0]    op_line [$];
    bit                                   ops_loaded = 1'b0;

    always #5 ui_clk = ~ui_clk;

    ddr_bridge_top dut_i (.*);

    mig_app_model model_i (.*);

    // --------------------------------------------------
    // failure reporting
    // --------------------------------------------------
    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [ddr_bridge_pkg::LINE_W-1:0] expected,
                               input logic [ddr_bridge_pkg::LINE_W-1:0] actual);
        if (actual !== expected) begin
            end_with_failure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    always @(negedge ui_clk) begin
        if (protocol_err === 1'b1) begin
            end_with_failure("the memory model saw an app interface protocol error");
        end
    end

    // --------------------------------------------------
    // stimulus file
    // --------------------------------------------------
    task automatic load_stimulus();
        int                                  fd;
        int                                  code;
        logic [63:0]                         tok;
        logic [8*200-1:0]                    rest;
        logic [ddr_bridge_pkg::WB_ADR_W-1:0] adr;
        logic [ddr_bridge_pkg::LINE_W-1:0]   line;

        fd = $fopen("tb/ddr_bridge_stimulus.txt", "r");
        if (fd == 0) begin
            end_with_failure("could not open the stimulus file tb/ddr_bridge_stimulus.txt");
        end
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", adr, line);
                if (code != 2 || (tok != "W" && tok != "R")) begin
                    end_with_failure("the stimulus file has a malformed operation line");
                end
                op_write.push_back(tok == "W");
                op_adr.push_back(adr);
                op_line.push_back(line);
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // one wishbone classic cycle
    // --------------------------------------------------
    task automatic run_op(input int idx);
        string                                name;
        bit                                   is_w;
        logic [ddr_bridge_pkg::WB_ADR_W-1:0]  adr;
        logic [ddr_bridge_pkg::LINE_W-1:0]    line;
        logic [ddr_bridge_pkg::APP_ADR_W-1:0] base;
        bit                                   cmd_seen;

        is_w     = op_write[idx];
        adr      = op_adr[idx];
        line     = op_line[idx];
        name     = $sformatf("op %0d %s %h", idx, is_w ? "write" : "read", adr);
        // word address in x16 columns, upper bits drop out
        base     = adr * 2;
        cmd_seen = 1'b0;

        @(posedge ui_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= is_w;
        wb_adr   <= adr;
        wb_dat_w <= line;
        do begin
            @(negedge ui_clk);
            if (!init_calib_complete) begin
                check_value({name, " quiet before calibration"}, '0,
                            {wb_ack, app_en, app_wdf_wren});
            end
            if (app_en && !cmd_seen) begin
                check_value({name, " beat 0 app address"}, base, app_addr);
                cmd_seen = 1'b1;
            end
        end while (wb_ack !== 1'b1);
        check_value({name, " command issued"}, 1, cmd_seen);
        if (!is_w) begin
            check_value({name, " read line"}, line, wb_dat_r);
        end

        // master drops the strobe the cycle after ack
        @(posedge ui_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge ui_clk);
        check_value({name, " ack one cycle wide"}, 0, wb_ack);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        int i;

        rst      = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        load_stimulus();
        ops_loaded = 1'b1;
        repeat (10) @(posedge ui_clk);
        rst <= 1'b1;
        @(negedge ui_clk);
        check_value("outputs after reset", '0, {wb_ack, app_en, app_wdf_wren});
        for (i = 0; i < op_write.size(); i++) begin
            run_op(i);
        end
        @(negedge ui_clk);
        if (protocol_err === 1'b1) begin
            end_with_failure("the memory model saw an app interface protocol error");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    initial begin
        wait (ops_loaded);
        repeat (op_write.size() * 40 + 200) @(posedge ui_clk);
        end_with_failure("watchdog expired before all operations were acknowledged");
    end

endmodule

// ==== list.f ====
design/ddr_bridge_pkg.sv
design/line_ctl_if.sv
design/beat_counter.sv
design/wr_line_path.sv
design/rd_line_path.sv
design/ddr_line_fsm.sv
design/ddr_bridge_top.sv
tb/mig_app_model.sv
tb/ddr_bridge_tb.sv

// ==== tb/ddr_bridge_stimulus.txt ====
# op addr line, one operation per line, addr is the 30-bit Wishbone word address in hex
# W writes line, R reads and expects line, 256-bit hex with beat 0 in the low half
R 00000100 0000020800000208000002080000020800000200000002000000020000000200
R 00000108 0000021800000218000002180000021800000210000002100000021000000210
W 00000100 1111222233334444555566667777888899990000aaaabbbbccccddddeeeeffff
W 00000108 0123456789abcdef0123456789abcdeffedcba9876543210fedcba9876543210
R 00000100 1111222233334444555566667777888899990000aaaabbbbccccddddeeeeffff
R 00000108 0123456789abcdef0123456789abcdeffedcba9876543210fedcba9876543210
W 3ffffff8 cafef00dcafef00dcafef00dcafef00d0badc0de0badc0de0badc0de0badc0de
R 03fffff8 cafef00dcafef00dcafef00dcafef00d0badc0de0badc0de0badc0de0badc0de
W 00000200 deadbeefdeadbeefdeadbeefdeadbeef00000001000000020000000300000004
W 00000200 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
R 00000200 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
R 00000100 1111222233334444555566667777888899990000aaaabbbbccccddddeeeeffff
R 00000000 0000000800000008000000080000000800000000000000000000000000000000
